/* logic/cpu_wait_pkg.sv */
////////////////////
// shared definitions for the cpu clock-enable and wait subsystem
// bus widths for rom, cpu data and shared ram
// fetch state and shared ram owner enums
////////////////////

package cpu_wait_pkg;

    ////////////////////
    // widths

    // rom word address, one byte per word
    localparam int rom_aw = 16;

    // cpu data bus
    localparam int data_w = 8;

    // shared ram address, 256 words
    localparam int ram_aw = 8;

    ////////////////////
    // enums

    // rom fetch states
    // idle while the held word matches or no request is pending
    // bus_cycle while a wishbone classic cycle is open
    typedef enum logic {
        idle      = 1'b0,
        bus_cycle = 1'b1
    } fetch_state_t;

    // owner of the shared ram in the current cycle
    // sub wins over cpu when both request
    typedef enum logic [1:0] {
        none = 2'd0,
        cpu  = 2'd1,
        sub  = 2'd2
    } ram_owner_t;

endpackage

/* logic/cen_divider.sv */
////////////////////
// base cpu clock-enable divider
// one single-cycle pulse every CEN_DIV system clocks
////////////////////

`timescale 1ns/1ns

module cen_divider #(
    parameter int CEN_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic base_cen
);

    // counter must hold 0..CEN_DIV-1, at least one bit
    localparam int CNT_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CEN_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

    logic [CNT_W-1:0] cnt;

    // modulo counter, wraps on the last phase
    // base_cen is registered so the first pulse shows CEN_DIV clocks after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            base_cen <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + CNT_ONE;
            end
            // pulse lands in the cycle after the last phase
            base_cen <= (cnt == CNT_LAST);
        end
    end

endmodule

/* logic/cpu_wait_gen.sv */
////////////////////
// cpu wait generator
// gates the base enable on rom misses and shared ram contention
// counts enables lost to rom waits and replays them in idle gaps
////////////////////

`timescale 1ns/1ns

module cpu_wait_gen #(
    parameter int RECOVERY   = 1,
    parameter int MISS_MAX_W = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic base_cen,
    // cpu cycle type, recovery only while all are high
    input  logic mreq_n,
    input  logic iorq_n,
    input  logic busak_n,
    // shared ram lost to the other device, never recovered
    input  logic dev_busy,
    // rom request and data valid from the fetch block
    input  logic rom_cs,
    input  logic rom_ok,
    output logic cpu_cen,
    output logic cpu_gate
);

    localparam logic [MISS_MAX_W-1:0] MISS_ONE = MISS_MAX_W'(1);

    ////////////////////
    // gate

    logic last_rom_cs;
    logic rom_cs_rise;
    logic rom_bad;
    logic locked;
    logic started;

    // a fresh rom select always costs one cycle, the fetch block
    // has not compared the new address yet
    assign rom_cs_rise = rom_cs & ~last_rom_cs;
    assign rom_bad     = (rom_cs & ~rom_ok) | rom_cs_rise;

    // gate closes at once on a wait and stays closed one more cycle
    assign cpu_gate = ~(rom_bad | dev_busy | locked);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // treat rom_cs as already high so reset does not look like an edge
            last_rom_cs <= 1'b1;
            locked      <= 1'b0;
            started     <= 1'b0;
        end else begin
            last_rom_cs <= rom_cs;
            if (rom_bad || dev_busy) begin
                locked <= 1'b1;
            end else begin
                locked  <= 1'b0;
                // first clean cycle arms the miss counter
                started <= 1'b1;
            end
        end
    end

    ////////////////////
    // recovery

    logic                  rec_allow;
    logic                  rec;
    logic                  cen_l;
    logic [MISS_MAX_W-1:0] miss_cnt;

    // only plain execution cycles may take an extra enable
    assign rec_allow = mreq_n & iorq_n & busak_n & (RECOVERY != 0);

    // recovery pulse sits between base enables and
    // never right after another enable, so pulses stay one apart
    assign rec = (miss_cnt != '0) & ~base_cen & rec_allow & ~cen_l;

    assign cpu_cen = (base_cen & cpu_gate) | rec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_l <= 1'b0;
        end else begin
            cen_l <= cpu_cen;
        end
    end

    // miss counter
    // up on a base enable eaten by a rom wait, saturating
    // down on each recovery pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_cnt <= '0;
        end else if (!started) begin
            miss_cnt <= '0;
        end else if (base_cen && !cpu_gate && !dev_busy) begin
            if (~&miss_cnt) begin
                miss_cnt <= miss_cnt + MISS_ONE;
            end
        end else if (rec) begin
            miss_cnt <= miss_cnt - MISS_ONE;
        end
    end

endmodule

/* logic/rom_fetch.sv */
////////////////////
// rom word holder and wishbone classic master
// one bus cycle per new address, repeats served from the held word
////////////////////

`timescale 1ns/1ns

module rom_fetch (
    input  logic                             clk,
    input  logic                             rst_n,
    // cpu side
    input  logic                             rom_cs,
    input  logic [cpu_wait_pkg::rom_aw-1:0]  rom_addr,
    output logic [cpu_wait_pkg::data_w-1:0]  rom_data,
    output logic                             rom_ok,
    // wishbone classic master
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic [cpu_wait_pkg::rom_aw-1:0]  wb_adr,
    input  logic [cpu_wait_pkg::data_w-1:0]  wb_dat_i,
    input  logic                             wb_ack
);

    cpu_wait_pkg::fetch_state_t state;

    // held word and the address it came from
    logic [cpu_wait_pkg::rom_aw-1:0] held_addr;
    logic [cpu_wait_pkg::data_w-1:0] held_data;
    logic                            held_valid;
    logic                            hit;

    ////////////////////
    // cpu side

    assign hit      = held_valid & (held_addr == rom_addr);
    // no request means nothing to wait for
    assign rom_ok   = ~rom_cs | hit;
    assign rom_data = held_data;

    ////////////////////
    // bus side

    // cyc and stb rise with the state change and fall
    // in the cycle after ack, both from the one state register
    assign wb_cyc = (state == cpu_wait_pkg::bus_cycle);
    assign wb_stb = (state == cpu_wait_pkg::bus_cycle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cpu_wait_pkg::idle;
            held_valid <= 1'b0;
        end else begin
            case (state)
                cpu_wait_pkg::idle: begin
                    // miss on the current address opens a cycle next clock
                    if (rom_cs && !hit) begin
                        state <= cpu_wait_pkg::bus_cycle;
                    end
                end
                cpu_wait_pkg::bus_cycle: begin
                    if (wb_ack) begin
                        state      <= cpu_wait_pkg::idle;
                        held_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= cpu_wait_pkg::idle;
                end
            endcase
        end
    end

    // address latch and returned word
    // wb_adr stays put for the whole cycle
    always_ff @(posedge clk) begin
        if (state == cpu_wait_pkg::idle && rom_cs && !hit) begin
            wb_adr <= rom_addr;
        end
        if (state == cpu_wait_pkg::bus_cycle && wb_ack) begin
            held_addr <= wb_adr;
            held_data <= wb_dat_i;
        end
    end

endmodule

/* logic/shared_ram_arb.sv */
////////////////////
// shared ram between cpu and sub device
// sub has priority, cpu sees dev_busy when it loses
////////////////////

`timescale 1ns/1ns

module shared_ram_arb (
    input  logic                             clk,
    // cpu port
    input  logic                             cpu_cs,
    input  logic                             cpu_we,
    input  logic [cpu_wait_pkg::ram_aw-1:0]  cpu_addr,
    input  logic [cpu_wait_pkg::data_w-1:0]  cpu_wdata,
    output logic [cpu_wait_pkg::data_w-1:0]  cpu_rdata,
    // sub port
    input  logic                             sub_cs,
    input  logic                             sub_we,
    input  logic [cpu_wait_pkg::ram_aw-1:0]  sub_addr,
    input  logic [cpu_wait_pkg::data_w-1:0]  sub_wdata,
    output logic [cpu_wait_pkg::data_w-1:0]  sub_rdata,
    output logic                             dev_busy
);

    localparam int RAM_DEPTH = 2 ** cpu_wait_pkg::ram_aw;

    logic [cpu_wait_pkg::data_w-1:0] mem [RAM_DEPTH];

    cpu_wait_pkg::ram_owner_t        owner;
    logic [cpu_wait_pkg::ram_aw-1:0] sel_addr;
    logic [cpu_wait_pkg::data_w-1:0] sel_wdata;
    logic                            sel_we;

    ////////////////////
    // arbitration

    // sub first, then cpu
    always_comb begin
        if (sub_cs) begin
            owner = cpu_wait_pkg::sub;
        end else if (cpu_cs) begin
            owner = cpu_wait_pkg::cpu;
        end else begin
            owner = cpu_wait_pkg::none;
        end
    end

    // cpu request lost this cycle
    assign dev_busy = cpu_cs & sub_cs;

    // single ram port follows the owner
    assign sel_addr  = (owner == cpu_wait_pkg::sub) ? sub_addr : cpu_addr;
    assign sel_wdata = (owner == cpu_wait_pkg::sub) ? sub_wdata : cpu_wdata;
    assign sel_we    = ((owner == cpu_wait_pkg::sub) & sub_we) |
                       ((owner == cpu_wait_pkg::cpu) & cpu_we);

    ////////////////////
    // ram

    always_ff @(posedge clk) begin
        if (sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // registered read, old data on a same-cycle write
    // each port keeps its last word until it owns the ram again
    always_ff @(posedge clk) begin
        if (owner == cpu_wait_pkg::cpu) begin
            cpu_rdata <= mem[sel_addr];
        end
        if (owner == cpu_wait_pkg::sub) begin
            sub_rdata <= mem[sel_addr];
        end
    end

endmodule

/* logic/cpu_bus_top.sv */
////////////////////
// cpu bus top level
// divider, wait generator, rom fetch and shared ram arbiter
////////////////////

`timescale 1ns/1ns

module cpu_bus_top #(
    parameter int CEN_DIV    = 4,
    parameter int RECOVERY   = 1,
    parameter int MISS_MAX_W = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // cpu rom bus
    input  logic                             cpu_rom_cs,
    input  logic [cpu_wait_pkg::rom_aw-1:0]  cpu_rom_addr,
    output logic [cpu_wait_pkg::data_w-1:0]  cpu_rom_data,
    // cpu shared ram bus
    input  logic                             cpu_ram_cs,
    input  logic                             cpu_ram_we,
    input  logic [cpu_wait_pkg::ram_aw-1:0]  cpu_ram_addr,
    input  logic [cpu_wait_pkg::data_w-1:0]  cpu_ram_wdata,
    output logic [cpu_wait_pkg::data_w-1:0]  cpu_ram_rdata,
    // cpu cycle type
    input  logic                             mreq_n,
    input  logic                             iorq_n,
    input  logic                             busak_n,
    // sub device port
    input  logic                             sub_cs,
    input  logic                             sub_we,
    input  logic [cpu_wait_pkg::ram_aw-1:0]  sub_addr,
    input  logic [cpu_wait_pkg::data_w-1:0]  sub_wdata,
    output logic [cpu_wait_pkg::data_w-1:0]  sub_rdata,
    // rom wishbone master
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic [cpu_wait_pkg::rom_aw-1:0]  wb_adr,
    input  logic [cpu_wait_pkg::data_w-1:0]  wb_dat_i,
    input  logic                             wb_ack,
    // cpu clock enable and wait gate
    output logic                             cpu_cen,
    output logic                             cpu_gate
);

    logic base_cen;
    logic rom_ok;
    logic dev_busy;

    cen_divider #(
        .CEN_DIV (CEN_DIV)
    ) cen_divider_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .base_cen (base_cen)
    );

    cpu_wait_gen #(
        .RECOVERY   (RECOVERY),
        .MISS_MAX_W (MISS_MAX_W)
    ) cpu_wait_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .base_cen (base_cen),
        .mreq_n   (mreq_n),
        .iorq_n   (iorq_n),
        .busak_n  (busak_n),
        .dev_busy (dev_busy),
        .rom_cs   (cpu_rom_cs),
        .rom_ok   (rom_ok),
        .cpu_cen  (cpu_cen),
        .cpu_gate (cpu_gate)
    );

    rom_fetch rom_fetch_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rom_cs   (cpu_rom_cs),
        .rom_addr (cpu_rom_addr),
        .rom_data (cpu_rom_data),
        .rom_ok   (rom_ok),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    shared_ram_arb shared_ram_arb_inst (
        .clk       (clk),
        .cpu_cs    (cpu_ram_cs),
        .cpu_we    (cpu_ram_we),
        .cpu_addr  (cpu_ram_addr),
        .cpu_wdata (cpu_ram_wdata),
        .cpu_rdata (cpu_ram_rdata),
        .sub_cs    (sub_cs),
        .sub_we    (sub_we),
        .sub_addr  (sub_addr),
        .sub_wdata (sub_wdata),
        .sub_rdata (sub_rdata),
        .dev_busy  (dev_busy)
    );

endmodule

/* tb/tb_rom_slave.sv */
////////////////////
// wishbone classic rom slave model
// seeded random ack delay of one to six cycles
// data is the low address byte xor a fixed key
////////////////////

`timescale 1ns/1ns

module tb_rom_slave (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic [cpu_wait_pkg::rom_aw-1:0]  wb_adr,
    output logic [cpu_wait_pkg::data_w-1:0]  wb_dat_o,
    output logic                             wb_ack
);

    localparam logic [cpu_wait_pkg::data_w-1:0] data_key = 'h5a;

    // fixed seed so every run sees the same delays
    integer      seed = 9;
    int unsigned draw;
    int          wait_cnt;
    logic        busy;

    // first cycle with stb draws a delay, ack follows after it
    // ack is single cycle, the master drops stb in the next clock
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!busy) begin
                    draw = $unsigned($random(seed));
                    // 0..5 extra cycles, one to six in total
                    wait_cnt <= int'(draw % 6);
                    busy     <= 1'b1;
                end else if (wait_cnt == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_o <= wb_adr[cpu_wait_pkg::data_w-1:0] ^ data_key;
                    busy     <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

/* tb/tb_cpu_bus.sv */
////////////////////
// testbench for the cpu bus top level
// clock, reset, golden file steps, rom slave model
// compare tasks, enable monitor and summary
////////////////////

`timescale 1ns/1ns

module tb_cpu_bus;

    localparam int cen_div = 4;

    logic                             clk;
    logic                             rst_n;
    logic                             cpu_rom_cs;
    logic [cpu_wait_pkg::rom_aw-1:0]  cpu_rom_addr;
    logic [cpu_wait_pkg::data_w-1:0]  cpu_rom_data;
    logic                             cpu_ram_cs;
    logic                             cpu_ram_we;
    logic [cpu_wait_pkg::ram_aw-1:0]  cpu_ram_addr;
    logic [cpu_wait_pkg::data_w-1:0]  cpu_ram_wdata;
    logic [cpu_wait_pkg::data_w-1:0]  cpu_ram_rdata;
    logic                             mreq_n;
    logic                             iorq_n;
    logic                             busak_n;
    logic                             sub_cs;
    logic                             sub_we;
    logic [cpu_wait_pkg::ram_aw-1:0]  sub_addr;
    logic [cpu_wait_pkg::data_w-1:0]  sub_wdata;
    logic [cpu_wait_pkg::data_w-1:0]  sub_rdata;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic [cpu_wait_pkg::rom_aw-1:0]  wb_adr;
    logic [cpu_wait_pkg::data_w-1:0]  wb_dat_i;
    logic                             wb_ack;
    logic                             cpu_cen;
    logic                             cpu_gate;

    // result counters
    int check_total = 0;
    int value_errors = 0;
    int spacing_errors = 0;
    int other_failures = 0;
    int step_line = 0;

    // monitor totals, snapshots taken at window edges
    int   cycle = 0;
    int   cyc_rises = 0;
    int   cen_total = 0;
    int   base_total = 0;
    int   gated_total = 0;
    logic cyc_last = 1'b0;
    logic cen_last = 1'b0;
    int   cen_start;
    int   base_start;
    int   gated_start;

    // shared ram contents as the golden writes leave them
    logic [cpu_wait_pkg::data_w-1:0] ram_model [2 ** cpu_wait_pkg::ram_aw];

    integer fd;
    integer r;
    string  line;

    cpu_bus_top #(
        .CEN_DIV    (cen_div),
        .RECOVERY   (1),
        .MISS_MAX_W (4)
    ) cpu_bus_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_rom_cs    (cpu_rom_cs),
        .cpu_rom_addr  (cpu_rom_addr),
        .cpu_rom_data  (cpu_rom_data),
        .cpu_ram_cs    (cpu_ram_cs),
        .cpu_ram_we    (cpu_ram_we),
        .cpu_ram_addr  (cpu_ram_addr),
        .cpu_ram_wdata (cpu_ram_wdata),
        .cpu_ram_rdata (cpu_ram_rdata),
        .mreq_n        (mreq_n),
        .iorq_n        (iorq_n),
        .busak_n       (busak_n),
        .sub_cs        (sub_cs),
        .sub_we        (sub_we),
        .sub_addr      (sub_addr),
        .sub_wdata     (sub_wdata),
        .sub_rdata     (sub_rdata),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack),
        .cpu_cen       (cpu_cen),
        .cpu_gate      (cpu_gate)
    );

    tb_rom_slave rom_slave_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // monitor, samples at the rising edge

    // base enable model: first pulse seen on the fifth edge after release,
    // then every cen_div edges
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (wb_cyc && !cyc_last) begin
                cyc_rises++;
            end
            cyc_last = wb_cyc;
            if (cpu_cen) begin
                cen_total++;
            end
            if (cycle > cen_div && (cycle - 1) % cen_div == 0) begin
                base_total++;
                if (!cpu_gate) begin
                    gated_total++;
                end
            end
            if (cpu_cen && cen_last) begin
                $display("cpu_cen was high in two consecutive cycles at cycle %0d", cycle);
                spacing_errors++;
            end
            cen_last = cpu_cen;
        end
    end

    ////////////////////
    // compare tasks

    task automatic check_data(input string name,
                              input logic [cpu_wait_pkg::data_w-1:0] expected,
                              input logic [cpu_wait_pkg::data_w-1:0] actual);
        check_total++;
        if (actual !== expected) begin
            $display("[ERROR] %s (golden line %0d) expected %02h actual %02h",
                     name, step_line, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        check_total++;
        if (actual != expected) begin
            $display("[ERROR] %s (golden line %0d) expected %0d actual %0d",
                     name, step_line, expected, actual);
            value_errors++;
        end
    endtask

    ////////////////////
    // bus steps

    // cpu_gate high ends the wait, max_low bounds the closed cycles
    task automatic wait_gate(input int max_low, output bit ok);
        int low;
        low = 0;
        ok  = 1'b0;
        while (!ok && low <= max_low) begin
            @(posedge clk);
            if (cpu_gate) begin
                ok = 1'b1;
            end else begin
                low++;
            end
        end
        if (!ok) begin
            $display("cpu_gate stayed closed longer than %0d cycles at golden line %0d",
                     max_low, step_line);
            other_failures++;
        end
    endtask

    task automatic rom_read(input logic [cpu_wait_pkg::rom_aw-1:0] addr,
                            input logic [cpu_wait_pkg::data_w-1:0] expected,
                            input int bus_cycles, input int max_low);
        int rises_before;
        bit ok;
        rises_before = cyc_rises;
        @(negedge clk);
        cpu_rom_cs   = 1'b1;
        cpu_rom_addr = addr;
        wait_gate(max_low, ok);
        @(negedge clk);
        if (ok) begin
            check_data("rom_data", expected, cpu_rom_data);
            check_count("rom_bus_cycles", bus_cycles, cyc_rises - rises_before);
        end
        cpu_rom_cs = 1'b0;
    endtask

    task automatic ram_write(input bit from_sub,
                             input logic [cpu_wait_pkg::ram_aw-1:0] addr,
                             input logic [cpu_wait_pkg::data_w-1:0] data);
        @(negedge clk);
        if (from_sub) begin
            sub_cs    = 1'b1;
            sub_we    = 1'b1;
            sub_addr  = addr;
            sub_wdata = data;
        end else begin
            cpu_ram_cs    = 1'b1;
            cpu_ram_we    = 1'b1;
            cpu_ram_addr  = addr;
            cpu_ram_wdata = data;
        end
        ram_model[addr] = data;
        @(negedge clk);
        sub_cs     = 1'b0;
        sub_we     = 1'b0;
        cpu_ram_cs = 1'b0;
        cpu_ram_we = 1'b0;
    endtask

    // read data is registered, one clock after the address
    task automatic ram_read(input logic [cpu_wait_pkg::ram_aw-1:0] addr,
                            input logic [cpu_wait_pkg::data_w-1:0] expected);
        @(negedge clk);
        cpu_ram_cs   = 1'b1;
        cpu_ram_we   = 1'b0;
        cpu_ram_addr = addr;
        @(negedge clk);
        cpu_ram_cs = 1'b0;
        check_data("ram_read", expected, cpu_ram_rdata);
    endtask

    // sub and cpu on the ram in the same cycle, the cpu must wait
    // while the sub gets its word
    task automatic ram_clash(input logic [cpu_wait_pkg::ram_aw-1:0] addr, input int expected);
        logic gate_seen;
        @(negedge clk);
        sub_cs       = 1'b1;
        sub_addr     = addr;
        cpu_ram_cs   = 1'b1;
        cpu_ram_addr = addr;
        @(posedge clk);
        gate_seen = cpu_gate;
        @(negedge clk);
        sub_cs     = 1'b0;
        cpu_ram_cs = 1'b0;
        check_count("clash_gate", expected, int'(gate_seen));
        check_data("clash_sub_rdata", ram_model[addr], sub_rdata);
    endtask

    // a cpu changes its cycle type only in the cycle after its own enable
    task automatic drive_mreq(input logic level);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 64) begin
            @(posedge clk);
            if (cpu_cen) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            $display("no cpu_cen pulse within %0d cycles at golden line %0d",
                     waited, step_line);
            other_failures++;
        end
        @(negedge clk);
        mreq_n = level;
    endtask

    // inhibit mode keeps the lost enables, recovery mode gives them back
    task automatic window_close(input bit inhibit);
        int cen_d;
        int base_d;
        int gated_d;
        @(negedge clk);
        cen_d   = cen_total - cen_start;
        base_d  = base_total - base_start;
        gated_d = gated_total - gated_start;
        if (inhibit) begin
            check_count("window_inhibit_cen", base_d - gated_d, cen_d);
        end else begin
            check_count("window_recovery_cen", base_d, cen_d);
        end
        if (gated_d == 0) begin
            $display("no base enable was gated inside the window closed at golden line %0d",
                     step_line);
            other_failures++;
        end
    endtask

    task automatic run_step(input string text);
        logic [63:0] kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        integer      n;
        n = $sscanf(text, "%s %h %h %h", kind, a, b, e);
        if (n != 4) begin
            $display("golden line %0d could not be parsed", step_line);
            other_failures++;
        end else begin
            case (kind)
                "rom":    rom_read(a[cpu_wait_pkg::rom_aw-1:0], e[cpu_wait_pkg::data_w-1:0],
                                   1, 64);
                "rep":    rom_read(a[cpu_wait_pkg::rom_aw-1:0], e[cpu_wait_pkg::data_w-1:0],
                                   0, 2);
                "cwr":    ram_write(1'b0, a[cpu_wait_pkg::ram_aw-1:0],
                                    b[cpu_wait_pkg::data_w-1:0]);
                "swr":    ram_write(1'b1, a[cpu_wait_pkg::ram_aw-1:0],
                                    b[cpu_wait_pkg::data_w-1:0]);
                "crd":    ram_read(a[cpu_wait_pkg::ram_aw-1:0], e[cpu_wait_pkg::data_w-1:0]);
                "clash":  ram_clash(a[cpu_wait_pkg::ram_aw-1:0], int'(e));
                "idle":   repeat (int'(a)) @(negedge clk);
                "mreq":   drive_mreq(a[0]);
                "wopen": begin
                    @(negedge clk);
                    cen_start   = cen_total;
                    base_start  = base_total;
                    gated_start = gated_total;
                end
                "wclose": window_close(a[0]);
                default: begin
                    $display("unknown step kind at golden line %0d", step_line);
                    other_failures++;
                end
            endcase
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        rst_n         = 1'b0;
        cpu_rom_cs    = 1'b0;
        cpu_rom_addr  = '0;
        cpu_ram_cs    = 1'b0;
        cpu_ram_we    = 1'b0;
        cpu_ram_addr  = '0;
        cpu_ram_wdata = '0;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        busak_n       = 1'b1;
        sub_cs        = 1'b0;
        sub_we        = 1'b0;
        sub_addr      = '0;
        sub_wdata     = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("tb/cpu_bus_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/cpu_bus_golden.txt");
            other_failures++;
        end else begin
            // one step per line, hash lines are notes
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                step_line++;
                if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    run_step(line);
                end
            end
            $fclose(fd);
        end

        $display("checks %0d, value errors %0d, spacing errors %0d, other failures %0d",
                 check_total, value_errors, spacing_errors, other_failures);
        if (value_errors == 0 && spacing_errors == 0 && other_failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb/cpu_bus_golden.txt */
# kind a b e, all fields hex, unused fields 0
# rom/rep: a rom address, e data | cwr/swr: a ram address, b byte | crd: a address, e data
# clash: a address, e cpu_gate | idle: a cycles | mreq: a level | wclose: a 0 recover, 1 inhibit
idle 10 0 0
rom 0100 0 5a
rom 1234 0 6e
rep 1234 0 6e
rep 1234 0 6e
cwr 10 c3 0
crd 10 0 c3
swr 20 3e 0
crd 20 0 3e
cwr 21 99 0
swr 21 47 0
crd 21 0 47
clash 20 0 0
crd 20 0 3e
idle 20 0 0
wopen 0 0 0
rom 00ff 0 a5
rom beef 0 b5
rom 7f80 0 da
rep 7f80 0 da
rom 0042 0 18
idle 40 0 0
wclose 0 0 0
idle 10 0 0
mreq 0 0 0
wopen 0 0 0
rom 0c3c 0 66
rom a5a5 0 ff
idle 20 0 0
wclose 1 0 0
mreq 1 0 0
idle 40 0 0
rom 0011 0 4b
rom 0022 0 78
rep 0022 0 78

/* tb.f */
logic/cpu_wait_pkg.sv
logic/cen_divider.sv
logic/cpu_wait_gen.sv
logic/rom_fetch.sv
logic/shared_ram_arb.sv
logic/cpu_bus_top.sv
tb/tb_rom_slave.sv
tb/tb_cpu_bus.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_cpu_bus -f tb.f -o sim_tb_cpu_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_cpu_bus > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
